// File: verilog.f
rtl/fifo_cfg_pkg.sv
rtl/gray_code_pkg.sv
rtl/cdc_sync.sv
rtl/fifo_mem.sv
rtl/fifo_write_ctrl.sv
rtl/fifo_read_ctrl.sv
rtl/async_fifo.sv
testbench/async_fifo_chk.sv
testbench/async_fifo_tb.sv

// File: run.sh
#!/bin/sh
# build the FIFO testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module async_fifo_tb -o async_fifo_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/async_fifo_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: testbench/async_fifo_tb.sv
// Testbench for the dual-clock FIFO: clocks, reset, reference queue, directed tests, summary
`timescale 1ns/1ps

module async_fifo_tb
	import fifo_cfg_pkg::*;
();

	localparam int DATA_WIDTH = DEFAULT_DATA_WIDTH;
	localparam int ADDR_WIDTH = DEFAULT_ADDR_WIDTH;
	localparam int DEPTH      = 2**ADDR_WIDTH;
	// bound on every wait loop, in clock cycles
	localparam int TIMEOUT    = 200;

	logic                  write_clk;
	logic                  read_clk;
	logic                  reset_rsync;
	logic                  write_en;
	logic [DATA_WIDTH-1:0] write_data;
	logic                  full;
	logic                  read_en;
	logic [DATA_WIDTH-1:0] read_data;
	logic                  empty;

	// reference model, pushed on accepted writes and popped on accepted reads
	logic [DATA_WIDTH-1:0] model_q [$];
	string                 current_test;
	int                    error_count = 0;
	int                    test_count  = 0;
	int                    total_errors;

	async_fifo #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) UUT (
		.write_clk(write_clk), .reset_rsync(reset_rsync), .write_en(write_en),
		.write_data(write_data), .full(full), .read_clk(read_clk), .read_en(read_en),
		.read_data(read_data), .empty(empty)
	);

	// unrelated clocks, 4 ns write and 6 ns read
	initial
	begin
		write_clk = 1'b0;
		forever #2 write_clk = ~write_clk;
	end

	initial
	begin
		read_clk = 1'b0;
		forever #3 read_clk = ~read_clk;
	end

	////////////////////
	// compares
	////////////////////

	task automatic check_word(input string what, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected)
		begin
			$display("error %s, %s: expected %h, actual %h", current_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("error %s, %s: expected %b, actual %b", current_test, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", current_test, what);
		error_count++;
	endtask

	task automatic finish_test(input int errors_before);
		test_count++;
		if (error_count == errors_before)
		begin
			$display("%s: ok", current_test);
		end
		else
		begin
			$display("%s: %0d errors", current_test, error_count - errors_before);
		end
	endtask

	////////////////////
	// stimulus
	////////////////////

	// strobe for the coming write edge, full is stable here so acceptance is known
	task automatic drive_write(input logic en, input logic [DATA_WIDTH-1:0] data);
		@(negedge write_clk);
		write_en   = en;
		write_data = data;
		if (en && !full)
		begin
			model_q.push_back(data);
		end
	endtask

	// one read strobe, the removed word is compared half a cycle after its edge
	task automatic read_word(input string what);
		logic                  taken;
		logic [DATA_WIDTH-1:0] expected;
		@(negedge read_clk);
		read_en  = 1'b1;
		taken    = !empty;
		expected = '0;
		if (taken && model_q.size() == 0)
		begin
			report_failure("empty is low but the reference queue holds no word");
			taken = 1'b0;
		end
		else if (taken)
		begin
			expected = model_q.pop_front();
		end
		@(negedge read_clk);
		read_en = 1'b0;
		if (taken)
		begin
			check_word(what, expected, read_data);
		end
	endtask

	// waits on falling edges of the flag's own clock
	task automatic wait_for_flag(input logic use_empty, input logic level);
		int   cycles;
		logic value;
		cycles = 0;
		value  = use_empty ? empty : full;
		while (value !== level && cycles < TIMEOUT)
		begin
			if (use_empty)
			begin
				@(negedge read_clk);
			end
			else
			begin
				@(negedge write_clk);
			end
			value = use_empty ? empty : full;
			cycles++;
		end
		if (value !== level)
		begin
			report_failure($sformatf("%s never went to %b", use_empty ? "empty" : "full", level));
		end
	endtask

	// five write cycles of reset, read inputs are already low
	task automatic apply_reset();
		@(negedge write_clk);
		reset_rsync = 1'b1;
		write_en    = 1'b0;
		repeat (5) @(negedge write_clk);
		reset_rsync = 1'b0;
		model_q.delete();
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic reset_state();
		int errors_before;
		errors_before = error_count;
		current_test  = "reset state";
		apply_reset();
		check_flag("empty", 1'b1, empty);
		check_flag("full", 1'b0, full);
		finish_test(errors_before);
	endtask

	task automatic fill_until_full();
		int errors_before;
		errors_before = error_count;
		current_test  = "fill until full";
		for (int i = 0; i < DEPTH; i++)
		begin
			check_flag("full before last write", 1'b0, full);
			drive_write(1'b1, DATA_WIDTH'(32'h1000_0000 + i));
		end
		// full rose on the last edge, so this word is dropped
		drive_write(1'b1, DATA_WIDTH'(32'hdead_beef));
		check_flag("full after last write", 1'b1, full);
		drive_write(1'b0, '0);
		check_flag("full after dropped write", 1'b1, full);
		finish_test(errors_before);
	endtask

	task automatic drain_in_order();
		int                    errors_before;
		logic [DATA_WIDTH-1:0] last_word;
		errors_before = error_count;
		current_test  = "drain in order";
		for (int i = 0; i < DEPTH; i++)
		begin
			wait_for_flag(1'b1, 1'b0);
			read_word("word order");
		end
		check_flag("empty after drain", 1'b1, empty);
		// last word stored by the fill test stays on read_data
		last_word = DATA_WIDTH'(32'h1000_0000 + DEPTH - 1);
		read_word("read while empty");
		check_word("read data while empty", last_word, read_data);
		check_flag("empty after read while empty", 1'b1, empty);
		wait_for_flag(1'b0, 1'b0);
		finish_test(errors_before);
	endtask

	task automatic random_stream();
		int errors_before;
		int cycles;
		bit writer_done;
		errors_before = error_count;
		current_test  = "random stream";
		writer_done   = 1'b0;
		fork
			begin
				// random gaps, drops while full are left to the model
				for (int i = 0; i < 40; i++)
				begin
					drive_write(1'($urandom_range(0, 1)), DATA_WIDTH'($urandom));
				end
				drive_write(1'b0, '0);
				writer_done = 1'b1;
			end
			begin
				cycles = 0;
				while (!(writer_done && model_q.size() == 0) && cycles < TIMEOUT)
				begin
					if ($urandom_range(0, 2) != 0)
					begin
						read_word("stream word");
					end
					else
					begin
						@(negedge read_clk);
					end
					cycles++;
				end
				if (model_q.size() != 0)
				begin
					report_failure("read side never drained the written words");
				end
			end
		join
		finish_test(errors_before);
	endtask

	task automatic reset_mid_stream();
		int errors_before;
		errors_before = error_count;
		current_test  = "reset mid stream";
		// fill completely so the reset has to clear full as well
		for (int i = 0; i < DEPTH; i++)
		begin
			drive_write(1'b1, DATA_WIDTH'(32'h0bad_0000 + i));
		end
		drive_write(1'b0, '0);
		check_flag("full before reset", 1'b1, full);
		// stale words are visible on the read side before the reset hits
		wait_for_flag(1'b1, 1'b0);
		apply_reset();
		check_flag("empty after reset", 1'b1, empty);
		check_flag("full after reset", 1'b0, full);
		for (int i = 0; i < 2; i++)
		begin
			drive_write(1'b1, DATA_WIDTH'(32'h600d_0000 + i));
		end
		drive_write(1'b0, '0);
		for (int i = 0; i < 2; i++)
		begin
			wait_for_flag(1'b1, 1'b0);
			read_word("word after reset");
		end
		// a leftover word would pull empty low again
		repeat (2 * SYNC_STAGES + 2) @(negedge read_clk);
		check_flag("empty after new words", 1'b1, empty);
		finish_test(errors_before);
	endtask

	initial
	begin
		void'($urandom(79));
		reset_rsync = 1'b1;
		write_en    = 1'b0;
		write_data  = '0;
		read_en     = 1'b0;
		reset_state();
		fill_until_full();
		drain_in_order();
		random_stream();
		reset_mid_stream();
		total_errors = error_count + int'(UUT.u_chk.fail_count);
		$display("tests %0d, check errors %0d, assertion failures %0d",
			test_count, error_count, UUT.u_chk.fail_count);
		if (total_errors == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: testbench/async_fifo_chk.sv
// Bound checker: concurrent assertions on pointer and flag behavior of the dual-clock FIFO
`timescale 1ns/1ps

module async_fifo_chk
	import gray_code_pkg::*;
#(
	parameter int ADDR_WIDTH = 1
)
(
	input logic                write_clk,
	input logic                read_clk,
	input logic                reset_rsync,
	input logic                read_reset,
	input logic                write_en,
	input logic                read_en,
	input logic                full,
	input logic                empty,
	input logic [ADDR_WIDTH:0] write_ptr_gray,
	input logic [ADDR_WIDTH:0] read_ptr_gray,
	input logic [ADDR_WIDTH:0] read_ptr_sync
);

	localparam int PTR_WIDTH = ADDR_WIDTH + 1;
	localparam logic [PTR_WIDTH-1:0] DEPTH = PTR_WIDTH'(2**ADDR_WIDTH);

	// failed assertions, read by the testbench summary
	int unsigned              fail_count = 0;
	logic [PTR_MAX_WIDTH-1:0] write_bin_wide;
	logic [PTR_MAX_WIDTH-1:0] read_bin_wide;
	logic [PTR_WIDTH-1:0]     fill_level;

	// occupancy as the write side sees it, stale read pointer included
	assign write_bin_wide = gray_to_bin(PTR_MAX_WIDTH'(write_ptr_gray));
	assign read_bin_wide  = gray_to_bin(PTR_MAX_WIDTH'(read_ptr_sync));
	assign fill_level     = write_bin_wide[PTR_WIDTH-1:0] - read_bin_wide[PTR_WIDTH-1:0];

	////////////////////
	// write domain
	////////////////////

	write_hold_full: assert property (@(posedge write_clk)
		(!reset_rsync && full && write_en) |=> $stable(write_ptr_gray))
	else
	begin
		$error("write pointer moved on a write while full");
		fail_count++;
	end

	write_gray_step: assert property (@(posedge write_clk)
		!reset_rsync |-> $onehot0(write_ptr_gray ^ $past(write_ptr_gray)))
	else
	begin
		$error("write Gray pointer changed in more than one bit");
		fail_count++;
	end

	// never more words than entries
	write_fill_bound: assert property (@(posedge write_clk) fill_level <= DEPTH)
	else
	begin
		$error("write side occupancy above the entry count");
		fail_count++;
	end

	full_after_reset: assert property (@(posedge write_clk) $fell(reset_rsync) |-> !full)
	else
	begin
		$error("full high right after reset");
		fail_count++;
	end

	////////////////////
	// read domain
	////////////////////

	read_hold_empty: assert property (@(posedge read_clk)
		(!read_reset && empty && read_en) |=> $stable(read_ptr_gray))
	else
	begin
		$error("read pointer moved on a read while empty");
		fail_count++;
	end

	read_gray_step: assert property (@(posedge read_clk)
		!read_reset |-> $onehot0(read_ptr_gray ^ $past(read_ptr_gray)))
	else
	begin
		$error("read Gray pointer changed in more than one bit");
		fail_count++;
	end

	empty_after_reset: assert property (@(posedge read_clk) $fell(read_reset) |-> empty)
	else
	begin
		$error("empty low right after read domain reset");
		fail_count++;
	end

endmodule

// attach to every FIFO top level, ports named as inside the DUT
bind async_fifo async_fifo_chk #(
	.ADDR_WIDTH(ADDR_WIDTH)
) u_chk (
	.write_clk(write_clk), .read_clk(read_clk), .reset_rsync(reset_rsync),
	.read_reset(read_reset), .write_en(write_en), .read_en(read_en), .full(full),
	.empty(empty), .write_ptr_gray(write_ptr_gray), .read_ptr_gray(read_ptr_gray),
	.read_ptr_sync(read_ptr_sync)
);

// File: rtl/async_fifo.sv
// Dual-clock FIFO top level: write control, word store, pointer synchronizers, read control
`timescale 1ns/1ps

module async_fifo
	import fifo_cfg_pkg::*;
#(
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH
)
(
	input  logic                  write_clk,
	input  logic                  reset_rsync,
	input  logic                  write_en,
	input  logic [DATA_WIDTH-1:0] write_data,
	output logic                  full,
	input  logic                  read_clk,
	input  logic                  read_en,
	output logic [DATA_WIDTH-1:0] read_data,
	output logic                  empty
);

	// write domain
	logic                  mem_write_en;
	logic [ADDR_WIDTH-1:0] write_addr;
	logic [ADDR_WIDTH:0]   write_ptr_gray;
	logic [ADDR_WIDTH:0]   read_ptr_sync;
	// read domain
	logic                  read_reset;
	logic [ADDR_WIDTH-1:0] read_addr;
	logic [ADDR_WIDTH:0]   read_ptr_gray;
	logic [ADDR_WIDTH:0]   write_ptr_sync;

	fifo_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_write_ctrl (
		.write_clk(write_clk), .reset_rsync(reset_rsync), .write_en(write_en),
		.read_ptr_sync(read_ptr_sync), .full(full), .mem_write_en(mem_write_en),
		.write_addr(write_addr), .write_ptr_gray(write_ptr_gray)
	);

	// read port loads whenever data is present
	fifo_mem #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) u_mem (
		.write_clk(write_clk), .mem_write_en(mem_write_en), .write_addr(write_addr),
		.write_data(write_data), .read_clk(read_clk), .read_load(~empty),
		.read_addr(read_addr), .read_data(read_data)
	);

	////////////////////
	// crossings
	////////////////////

	// system reset held into the read domain, released SYNC_STAGES edges later
	cdc_sync #(.WIDTH(1), .RESET_VALUE(1'b1)) u_read_reset_sync (
		.clk(read_clk), .reset(reset_rsync), .data_in(1'b0), .data_out(read_reset)
	);

	// write pointer into the read domain
	cdc_sync #(.WIDTH(ADDR_WIDTH + 1)) u_write_ptr_sync (
		.clk(read_clk), .reset(read_reset), .data_in(write_ptr_gray), .data_out(write_ptr_sync)
	);

	// read pointer into the write domain
	cdc_sync #(.WIDTH(ADDR_WIDTH + 1)) u_read_ptr_sync (
		.clk(write_clk), .reset(reset_rsync), .data_in(read_ptr_gray), .data_out(read_ptr_sync)
	);

	fifo_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_read_ctrl (
		.read_clk(read_clk), .read_reset(read_reset), .read_en(read_en),
		.write_ptr_sync(write_ptr_sync), .empty(empty), .read_addr(read_addr),
		.read_ptr_gray(read_ptr_gray)
	);

endmodule

// File: rtl/fifo_read_ctrl.sv
// FIFO read control: read pointer, Gray copy, empty detection, store read address
`timescale 1ns/1ps

module fifo_read_ctrl
	import gray_code_pkg::*;
#(
	parameter int ADDR_WIDTH = 1
)
(
	input  logic                  read_clk,
	input  logic                  read_reset,
	input  logic                  read_en,
	input  logic [ADDR_WIDTH:0]   write_ptr_sync,
	output logic                  empty,
	output logic [ADDR_WIDTH-1:0] read_addr,
	output logic [ADDR_WIDTH:0]   read_ptr_gray
);

	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	logic [PTR_WIDTH-1:0]     read_ptr;
	logic [PTR_WIDTH-1:0]     read_ptr_next;
	logic [PTR_MAX_WIDTH-1:0] gray_next_wide;
	logic                     read_accept;

	////////////////////
	// next pointer
	////////////////////

	assign read_ptr_next  = read_ptr + 1'b1;
	assign gray_next_wide = bin_to_gray(PTR_MAX_WIDTH'(read_ptr_next));

	////////////////////
	// status and store
	////////////////////

	// equal pointers, nothing left to read
	// write pointer arrives late, so empty can only be late to fall
	assign empty = (read_ptr_gray == write_ptr_sync);

	// reads while empty are ignored
	assign read_accept = read_en && !empty;

	// store index drops the wrap bit
	assign read_addr = read_ptr[ADDR_WIDTH-1:0];

	always_ff @(posedge read_clk)
	begin
		if (read_reset)
		begin
			read_ptr      <= '0;
			read_ptr_gray <= '0;
		end
		else if (read_accept)
		begin
			read_ptr      <= read_ptr_next;
			read_ptr_gray <= gray_next_wide[PTR_WIDTH-1:0];
		end
	end

endmodule

// File: rtl/fifo_write_ctrl.sv
// FIFO write control: write pointer, Gray copy, full detection, store write enable
`timescale 1ns/1ps

module fifo_write_ctrl
	import gray_code_pkg::*;
#(
	parameter int ADDR_WIDTH = 1
)
(
	input  logic                  write_clk,
	input  logic                  reset_rsync,
	input  logic                  write_en,
	input  logic [ADDR_WIDTH:0]   read_ptr_sync,
	output logic                  full,
	output logic                  mem_write_en,
	output logic [ADDR_WIDTH-1:0] write_addr,
	output logic [ADDR_WIDTH:0]   write_ptr_gray
);

	// extra msb marks a wrap of the store
	localparam int PTR_WIDTH = ADDR_WIDTH + 1;

	// top two Gray bits differ when the writer is one lap ahead
	localparam logic [PTR_WIDTH-1:0] FULL_MASK = PTR_WIDTH'(3) << (PTR_WIDTH - 2);

	logic [PTR_WIDTH-1:0]     write_ptr;
	logic [PTR_WIDTH-1:0]     write_ptr_next;
	logic [PTR_MAX_WIDTH-1:0] gray_next_wide;

	////////////////////
	// next pointer
	////////////////////

	assign write_ptr_next = write_ptr + 1'b1;
	// convert at full package width, keep the low bits
	assign gray_next_wide = bin_to_gray(PTR_MAX_WIDTH'(write_ptr_next));

	////////////////////
	// status and store
	////////////////////

	// read pointer is stale by the sync delay, so full can only be late to fall
	assign full = (write_ptr_gray == (read_ptr_sync ^ FULL_MASK));

	// writes while full are dropped here
	assign mem_write_en = write_en && !full;

	assign write_addr = write_ptr[ADDR_WIDTH-1:0];

	// binary and Gray pointers move together on each accepted write
	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			write_ptr      <= '0;
			write_ptr_gray <= '0;
		end
		else if (mem_write_en)
		begin
			write_ptr      <= write_ptr_next;
			write_ptr_gray <= gray_next_wide[PTR_WIDTH-1:0];
		end
	end

endmodule

// File: rtl/fifo_mem.sv
// FIFO word store with a write-domain write port and a registered read-domain read port
`timescale 1ns/1ps

module fifo_mem
#(
	parameter int DATA_WIDTH = 1,
	parameter int ADDR_WIDTH = 1
)
(
	input  logic                  write_clk,
	input  logic                  mem_write_en,
	input  logic [ADDR_WIDTH-1:0] write_addr,
	input  logic [DATA_WIDTH-1:0] write_data,
	input  logic                  read_clk,
	input  logic                  read_load,
	input  logic [ADDR_WIDTH-1:0] read_addr,
	output logic [DATA_WIDTH-1:0] read_data
);

	// one word per entry
	logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

	// write port, owned by the write clock
	always_ff @(posedge write_clk)
	begin
		if (mem_write_en)
		begin
			mem[write_addr] <= write_data;
		end
	end

	// read port, only loads while the FIFO holds data
	// so read_data keeps the last word once empty
	always_ff @(posedge read_clk)
	begin
		if (read_load)
		begin
			read_data <= mem[read_addr];
		end
	end

endmodule

// File: rtl/cdc_sync.sv
// Multi-bit flop chain synchronizer with a parameterized reset value
`timescale 1ns/1ps

module cdc_sync
	import fifo_cfg_pkg::*;
#(
	parameter int WIDTH = 1,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
)
(
	input  logic             clk,
	input  logic             reset,
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out
);

	// stage 0 samples the foreign domain, the last stage is safe to use
	logic [WIDTH-1:0] sync_q [SYNC_STAGES];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// whole chain returns to the idle value
			for (int i = 0; i < SYNC_STAGES; i++)
			begin
				sync_q[i] <= RESET_VALUE;
			end
		end
		else
		begin
			sync_q[0] <= data_in;
			// shift toward the output
			for (int i = 1; i < SYNC_STAGES; i++)
			begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Gray inputs move one bit per step, so any sample is a valid pointer
	assign data_out = sync_q[SYNC_STAGES-1];

endmodule

// File: rtl/gray_code_pkg.sv
// Gray code package: pointer width limit, binary to Gray and Gray to binary conversion
package gray_code_pkg;

	// widest pointer the conversions handle
	// narrower pointers are zero extended by the caller
	localparam int PTR_MAX_WIDTH = 17;

	// neighbouring binary values map to codes one bit apart
	function automatic logic [PTR_MAX_WIDTH-1:0] bin_to_gray(
		input logic [PTR_MAX_WIDTH-1:0] bin
	);
		return bin ^ (bin >> 1);
	endfunction

	// each binary bit is the xor of all Gray bits at and above it
	function automatic logic [PTR_MAX_WIDTH-1:0] gray_to_bin(
		input logic [PTR_MAX_WIDTH-1:0] gray
	);
		logic [PTR_MAX_WIDTH-1:0] bin;
		bin[PTR_MAX_WIDTH-1] = gray[PTR_MAX_WIDTH-1];
		// walk down from the msb
		for (int i = PTR_MAX_WIDTH - 2; i >= 0; i--)
		begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

// File: rtl/fifo_cfg_pkg.sv
// FIFO configuration package: default data width, default address width, synchronizer depth
package fifo_cfg_pkg;

	////////////////////
	// geometry
	////////////////////

	// width of one stored word in bits
	localparam int DEFAULT_DATA_WIDTH = 32;

	// log2 of the entry count, so four entries by default
	localparam int DEFAULT_ADDR_WIDTH = 2;

	////////////////////
	// clock crossing
	////////////////////

	// flops in every synchronizer chain, pointers and reset alike
	localparam int SYNC_STAGES = 2;

endpackage
